// File: hw/bmu_arith_logic.sv
// ==============================
// Shift-and-add datapath
// Logic and single-bit datapath
// One stage register per group
// ==============================

`timescale 1ns/1ns
`default_nettype none

module bmu_arith_logic
    import bmu_pkg::*;
(
    input  var logic        clk_i,
    input  var logic        clk_en_i,
    input  var data_word_t  operand_a_i,
    input  var data_word_t  operand_b_i,
    input  var bmu_opcode_t opcode_i,
    output data_word_t      shadd_result_o,
    output data_word_t      logic_result_o
);

    // ==============================
    // Shift-and-add
    // ==============================
    logic [1:0] shift_amount;
    logic       shadd_legal;
    data_word_t shadd_result;

    always_comb begin
        shift_amount = 2'd0;
        shadd_legal  = 1'b1;
        case (opcode_i)
            OP_ADD:    shift_amount = 2'd0;
            OP_SH1ADD: shift_amount = 2'd1;
            OP_SH2ADD: shift_amount = 2'd2;
            OP_SH3ADD: shift_amount = 2'd3;
            default:   shadd_legal  = 1'b0;
        endcase
    end

    // B plus scaled A, carry out of bit 31 is dropped
    assign shadd_result = shadd_legal ? (operand_b_i + (operand_a_i << shift_amount)) : '0;

    // ==============================
    // Logic and single-bit
    // ==============================
    bit_index_t bit_index;
    data_word_t bit_mask;
    data_word_t bit_shifted;
    data_word_t logic_result;

    // Position comes from the low bits of B
    assign bit_index   = operand_b_i[COUNT_WIDTH-2:0];
    assign bit_mask    = data_word_t'(1) << bit_index;
    assign bit_shifted = operand_a_i >> bit_index;

    always_comb begin
        case (opcode_i)
            OP_ANDN: logic_result = operand_a_i & ~operand_b_i;
            OP_ORN:  logic_result = operand_a_i | ~operand_b_i;
            OP_XNOR: logic_result = ~(operand_a_i ^ operand_b_i);
            OP_BCLR: logic_result = operand_a_i & ~bit_mask;
            // Selected bit lands in bit 0
            OP_BEXT: logic_result = {{(DATA_WIDTH-1){1'b0}}, bit_shifted[0]};
            OP_BINV: logic_result = operand_a_i ^ bit_mask;
            OP_BSET: logic_result = operand_a_i | bit_mask;
            default: logic_result = '0;
        endcase
    end

    // Stage registers, held while the enable is low
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            shadd_result_o <= shadd_result;
            logic_result_o <= logic_result;
        end
    end

endmodule : bmu_arith_logic

`default_nettype wire

// File: hw/bmu_bit_count.sv
// ==============================
// Leading and trailing zero count
// Population count
// Count stage register and widening
// ==============================

`timescale 1ns/1ns
`default_nettype none

module bmu_bit_count
    import bmu_pkg::*;
(
    input  var logic        clk_i,
    input  var logic        clk_en_i,
    input  var data_word_t  operand_a_i,
    input  var bmu_opcode_t opcode_i,
    output data_word_t      count_result_o
);

    // ==============================
    // Zero count
    // ==============================
    data_word_t reversed_a;
    data_word_t zero_count_operand;
    bit_index_t lz_count;
    logic       all_zero;
    count_t     zero_count;

    // Bit reversal turns trailing zeros into leading zeros
    always_comb begin
        for (int i = 0; i < DATA_WIDTH; i++) begin
            reversed_a[DATA_WIDTH-1-i] = operand_a_i[i];
        end
    end

    assign zero_count_operand = (opcode_i == OP_CTZ) ? reversed_a : operand_a_i;

    // Scan upward, the highest set bit wins
    always_comb begin
        lz_count = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            if (zero_count_operand[i]) begin
                lz_count = bit_index_t'(DATA_WIDTH - 1 - i);
            end
        end
    end

    assign all_zero = ~|zero_count_operand;

    // An all-zero word counts as the full width
    assign zero_count = all_zero ? count_t'(DATA_WIDTH) : {1'b0, lz_count};

    // ==============================
    // Population count
    // ==============================
    count_t pop_count;

    always_comb begin
        pop_count = '0;
        for (int i = 0; i < DATA_WIDTH; i++) begin
            pop_count = pop_count + count_t'(operand_a_i[i]);
        end
    end

    // ==============================
    // Selection and stage
    // ==============================
    count_t count_sel;
    count_t count_q;

    always_comb begin
        case (opcode_i)
            OP_CLZ:  count_sel = zero_count;
            OP_CTZ:  count_sel = zero_count;
            OP_CPOP: count_sel = pop_count;
            default: count_sel = '0;
        endcase
    end

    // Only the narrow count is staged
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            count_q <= count_sel;
        end
    end

    // Zero-extend to a full word after the register
    assign count_result_o = {{(DATA_WIDTH-COUNT_WIDTH){1'b0}}, count_q};

endmodule : bmu_bit_count

`default_nettype wire

// File: hw/bmu_compare_rotate.sv
// ==============================
// Signed and unsigned min/max
// Left and right rotates
// One stage register per group
// ==============================

`timescale 1ns/1ns
`default_nettype none

module bmu_compare_rotate
    import bmu_pkg::*;
(
    input  var logic        clk_i,
    input  var logic        clk_en_i,
    input  var data_word_t  operand_a_i,
    input  var data_word_t  operand_b_i,
    input  var bmu_opcode_t opcode_i,
    output data_word_t      compare_result_o,
    output data_word_t      rotate_result_o
);

    // ==============================
    // Compare
    // ==============================
    logic       a_less_signed;
    logic       a_less_unsigned;
    data_word_t compare_result;

    assign a_less_signed   = $signed(operand_a_i) < $signed(operand_b_i);
    assign a_less_unsigned = operand_a_i < operand_b_i;

    always_comb begin
        case (opcode_i)
            OP_MAX:  compare_result = a_less_signed   ? operand_b_i : operand_a_i;
            OP_MAXU: compare_result = a_less_unsigned ? operand_b_i : operand_a_i;
            OP_MIN:  compare_result = a_less_signed   ? operand_a_i : operand_b_i;
            OP_MINU: compare_result = a_less_unsigned ? operand_a_i : operand_b_i;
            default: compare_result = '0;
        endcase
    end

    // ==============================
    // Rotate
    // ==============================
    bit_index_t                rotate_amount;
    logic [2*DATA_WIDTH-1:0]   rotate_double;
    logic [2*DATA_WIDTH-1:0]   rol_shifted;
    logic [2*DATA_WIDTH-1:0]   ror_shifted;
    data_word_t                rotate_result;

    // A placed twice, so a plain shift wraps the bits around
    assign rotate_amount = operand_b_i[COUNT_WIDTH-2:0];
    assign rotate_double = {operand_a_i, operand_a_i};
    assign rol_shifted   = rotate_double << rotate_amount;
    assign ror_shifted   = rotate_double >> rotate_amount;

    always_comb begin
        case (opcode_i)
            // Upper half for left, lower half for right
            OP_ROL:  rotate_result = rol_shifted[2*DATA_WIDTH-1:DATA_WIDTH];
            OP_ROR:  rotate_result = ror_shifted[DATA_WIDTH-1:0];
            default: rotate_result = '0;
        endcase
    end

    // Stage registers
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            compare_result_o <= compare_result;
            rotate_result_o  <= rotate_result;
        end
    end

endmodule : bmu_compare_rotate

`default_nettype wire

// File: hw/bmu_pkg.sv
// ==============================
// Bit manipulation unit package
// Word and count widths
// Operation class and opcode encodings
// Operation struct
// ==============================

`default_nettype none

package bmu_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int DATA_WIDTH  = 32;
    // Counts reach 32, so one bit more than an index
    localparam int COUNT_WIDTH = 6;

    typedef logic [DATA_WIDTH-1:0]  data_word_t;
    typedef logic [COUNT_WIDTH-2:0] bit_index_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // ==============================
    // Operation groups
    // ==============================
    typedef logic [2:0] bmu_class_t;

    localparam bmu_class_t CLASS_SHADD   = 3'd0;
    localparam bmu_class_t CLASS_COUNT   = 3'd1;
    localparam bmu_class_t CLASS_COMPARE = 3'd2;
    localparam bmu_class_t CLASS_ROTATE  = 3'd3;
    localparam bmu_class_t CLASS_LOGIC   = 3'd4;

    // Opcodes restart from 0 inside each group
    typedef logic [2:0] bmu_opcode_t;

    // Shift-and-add group
    localparam bmu_opcode_t OP_ADD    = 3'd0;
    localparam bmu_opcode_t OP_SH1ADD = 3'd1;
    localparam bmu_opcode_t OP_SH2ADD = 3'd2;
    localparam bmu_opcode_t OP_SH3ADD = 3'd3;

    // Bit count group
    localparam bmu_opcode_t OP_CLZ  = 3'd0;
    localparam bmu_opcode_t OP_CTZ  = 3'd1;
    localparam bmu_opcode_t OP_CPOP = 3'd2;

    // Compare group
    localparam bmu_opcode_t OP_MAX  = 3'd0;
    localparam bmu_opcode_t OP_MAXU = 3'd1;
    localparam bmu_opcode_t OP_MIN  = 3'd2;
    localparam bmu_opcode_t OP_MINU = 3'd3;

    // Rotate group
    localparam bmu_opcode_t OP_ROL = 3'd0;
    localparam bmu_opcode_t OP_ROR = 3'd1;

    // Logic and single-bit group
    localparam bmu_opcode_t OP_ANDN = 3'd0;
    localparam bmu_opcode_t OP_ORN  = 3'd1;
    localparam bmu_opcode_t OP_XNOR = 3'd2;
    localparam bmu_opcode_t OP_BCLR = 3'd3;
    localparam bmu_opcode_t OP_BEXT = 3'd4;
    localparam bmu_opcode_t OP_BINV = 3'd5;
    localparam bmu_opcode_t OP_BSET = 3'd6;

    // Class in the upper bits, opcode below
    typedef struct packed {
        bmu_class_t  op_class;
        bmu_opcode_t opcode;
    } bmu_op_t;

endpackage : bmu_pkg

`default_nettype wire

// File: hw/bmu_top.sv
// ==============================
// Bit manipulation unit top level
// Class and valid stage registers
// Final result selection
// ==============================

`timescale 1ns/1ns
`default_nettype none

module bmu_top
    import bmu_pkg::*;
(
    input  var logic       clk_i,
    input  var logic       rst_n_i,
    input  var logic       clk_en_i,
    input  var data_word_t operand_a_i,
    input  var data_word_t operand_b_i,
    input  var bmu_op_t    operation_i,
    input  var logic       data_valid_i,
    output data_word_t     result_o,
    output logic           data_valid_o
);

    // ==============================
    // Datapath groups
    // ==============================
    data_word_t shadd_result;
    data_word_t logic_result;
    data_word_t compare_result;
    data_word_t rotate_result;
    data_word_t count_result;

    // Every group sees the same opcode and operands
    bmu_arith_logic u_arith_logic (
        .clk_i          (clk_i),
        .clk_en_i       (clk_en_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .opcode_i       (operation_i.opcode),
        .shadd_result_o (shadd_result),
        .logic_result_o (logic_result)
    );

    bmu_compare_rotate u_compare_rotate (
        .clk_i            (clk_i),
        .clk_en_i         (clk_en_i),
        .operand_a_i      (operand_a_i),
        .operand_b_i      (operand_b_i),
        .opcode_i         (operation_i.opcode),
        .compare_result_o (compare_result),
        .rotate_result_o  (rotate_result)
    );

    bmu_bit_count u_bit_count (
        .clk_i          (clk_i),
        .clk_en_i       (clk_en_i),
        .operand_a_i    (operand_a_i),
        .opcode_i       (operation_i.opcode),
        .count_result_o (count_result)
    );

    // ==============================
    // Control stage
    // ==============================
    bmu_class_t class_q;

    // Class travels alongside the group results
    always_ff @(posedge clk_i) begin
        if (clk_en_i) begin
            class_q <= operation_i.op_class;
        end
    end

    // Reset wins over the enable
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_valid_o <= 1'b0;
        end else if (clk_en_i) begin
            data_valid_o <= data_valid_i;
        end
    end

    // Final mux on the registered class only
    always_comb begin
        case (class_q)
            CLASS_SHADD:   result_o = shadd_result;
            CLASS_COUNT:   result_o = count_result;
            CLASS_COMPARE: result_o = compare_result;
            CLASS_ROTATE:  result_o = rotate_result;
            CLASS_LOGIC:   result_o = logic_result;
            default:       result_o = '0;
        endcase
    end

endmodule : bmu_top

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the BMU testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timescale 1ns/1ns --top-module bmu_tb -Mdir "$BUILD_DIR" -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vbmu_tb" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG_FILE"; then
    exit 1
fi
exit 0

// File: verification/bmu_checker.sv
// ==============================
// Reference model of the bit manipulation unit
// Expectation staged one enabled cycle
// Comparison against DUT outputs
// ==============================

`timescale 1ns/1ns
`default_nettype none

module bmu_checker
    import bmu_pkg::*;
(
    input  var logic       clk_i,
    input  var logic       rst_n_i,
    input  var logic       clk_en_i,
    input  var data_word_t operand_a_i,
    input  var data_word_t operand_b_i,
    input  var bmu_op_t    operation_i,
    input  var logic       data_valid_i,
    input  var data_word_t dut_result_i,
    input  var logic       dut_valid_i,
    output int             error_count_o
);

    // ==============================
    // Reference model
    // ==============================
    function automatic data_word_t model_result(data_word_t a, data_word_t b, bmu_op_t op);
        data_word_t r;
        int         n;
        logic       found;
        r     = '0;
        n     = int'(b[4:0]);
        found = 1'b0;
        case (op.op_class)
            // B plus A scaled by 1, 2, 4 or 8
            CLASS_SHADD: if (op.opcode <= 3'd3) r = b + (a << op.opcode);
            CLASS_COUNT: begin
                if (op.opcode == OP_CLZ || op.opcode == OP_CTZ) begin
                    // No set bit means the full width
                    r = 32;
                    for (int k = 0; k < 32; k++) begin
                        if (!found && ((op.opcode == OP_CLZ) ? a[31-k] : a[k])) begin
                            r     = k;
                            found = 1'b1;
                        end
                    end
                end else if (op.opcode == OP_CPOP) begin
                    r = $countones(a);
                end
            end
            CLASS_COMPARE: begin
                case (op.opcode)
                    OP_MAX:  r = ($signed(a) >= $signed(b)) ? a : b;
                    OP_MAXU: r = (a >= b) ? a : b;
                    OP_MIN:  r = ($signed(a) <= $signed(b)) ? a : b;
                    OP_MINU: r = (a <= b) ? a : b;
                    default: r = '0;
                endcase
            end
            CLASS_ROTATE: begin
                // Zero amount returns A as it is
                if (op.opcode == OP_ROL) r = (n == 0) ? a : ((a << n) | (a >> (32 - n)));
                if (op.opcode == OP_ROR) r = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
            end
            CLASS_LOGIC: begin
                case (op.opcode)
                    OP_ANDN: r = a & ~b;
                    OP_ORN:  r = a | ~b;
                    OP_XNOR: r = ~(a ^ b);
                    OP_BCLR: r = a & ~(32'h1 << n);
                    OP_BEXT: r = (a >> n) & 32'h1;
                    OP_BINV: r = a ^ (32'h1 << n);
                    OP_BSET: r = a | (32'h1 << n);
                    default: r = '0;
                endcase
            end
            default: r = '0;
        endcase
        return r;
    endfunction

    // ==============================
    // Prediction and comparison
    // ==============================
    data_word_t exp_result;
    logic       exp_valid;
    int         errors;

    initial errors = 0;

    assign error_count_o = errors;

    // Prediction advances only on enabled edges, reset clears the valid
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            exp_valid <= 1'b0;
        end else if (clk_en_i) begin
            exp_valid  <= data_valid_i;
            exp_result <= model_result(operand_a_i, operand_b_i, operation_i);
        end
    end

    // Falling edge, outputs are settled here
    always @(negedge clk_i) begin
        if (rst_n_i === 1'b1) begin
            if (dut_valid_i !== exp_valid) begin
                $display("FAIL t=%0t data_valid_o expected %b got %b",
                         $time, exp_valid, dut_valid_i);
                errors++;
            end
            if (exp_valid && dut_result_i !== exp_result) begin
                $display("FAIL t=%0t result_o expected %h got %h",
                         $time, exp_result, dut_result_i);
                errors++;
            end
        end
    end

endmodule : bmu_checker

`default_nettype wire

// File: verification/bmu_tb.sv
// ==============================
// Testbench for the bit manipulation unit
// Clock, reset and stimulus
// Test sequencing and summary
// ==============================

`timescale 1ns/1ns
`default_nettype none

module bmu_tb
    import bmu_pkg::*;
();

    logic       clk_i;
    logic       rst_n_i;
    logic       clk_en;
    data_word_t operand_a;
    data_word_t operand_b;
    bmu_op_t    operation;
    logic       data_valid_in;
    data_word_t result;
    logic       data_valid_out;
    int         check_errors;
    int         timeout_count;
    int         errors_before;
    int         stall_left;

    bmu_top u_bmu_top (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .clk_en_i     (clk_en),
        .operand_a_i  (operand_a),
        .operand_b_i  (operand_b),
        .operation_i  (operation),
        .data_valid_i (data_valid_in),
        .result_o     (result),
        .data_valid_o (data_valid_out)
    );

    bmu_checker u_checker (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .clk_en_i      (clk_en),
        .operand_a_i   (operand_a),
        .operand_b_i   (operand_b),
        .operation_i   (operation),
        .data_valid_i  (data_valid_in),
        .dut_result_i  (result),
        .dut_valid_i   (data_valid_out),
        .error_count_o (check_errors)
    );

    // 20 ns period
    always #10 clk_i = ~clk_i;

    // ==============================
    // Stimulus helpers
    // ==============================
    // Drive point sits 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic drive(input data_word_t a, input data_word_t b, input bmu_op_t op,
                         input logic valid);
        operand_a     = a;
        operand_b     = b;
        operation     = op;
        data_valid_in = valid;
        next_cycle();
    endtask

    // Legal class with a legal opcode inside it
    function automatic bmu_op_t random_op();
        bmu_op_t op;
        op.op_class = bmu_class_t'($urandom_range(4, 0));
        case (op.op_class)
            CLASS_SHADD:   op.opcode = bmu_opcode_t'($urandom_range(3, 0));
            CLASS_COUNT:   op.opcode = bmu_opcode_t'($urandom_range(2, 0));
            CLASS_COMPARE: op.opcode = bmu_opcode_t'($urandom_range(3, 0));
            CLASS_ROTATE:  op.opcode = bmu_opcode_t'($urandom_range(1, 0));
            default:       op.opcode = bmu_opcode_t'($urandom_range(6, 0));
        endcase
        return op;
    endfunction

    // Either an unused class or an unused opcode of a used class
    function automatic bmu_op_t unused_op();
        bmu_op_t op;
        if ($urandom_range(1, 0) == 0) begin
            op.op_class = bmu_class_t'($urandom_range(7, 5));
            op.opcode   = bmu_opcode_t'($urandom_range(7, 0));
        end else begin
            op.op_class = bmu_class_t'($urandom_range(4, 0));
            case (op.op_class)
                CLASS_SHADD:   op.opcode = bmu_opcode_t'($urandom_range(7, 4));
                CLASS_COUNT:   op.opcode = bmu_opcode_t'($urandom_range(7, 3));
                CLASS_COMPARE: op.opcode = bmu_opcode_t'($urandom_range(7, 4));
                CLASS_ROTATE:  op.opcode = bmu_opcode_t'($urandom_range(7, 2));
                default:       op.opcode = 3'd7;
            endcase
        end
        return op;
    endfunction

    // Bounded wait for the output valid to reach a level
    task automatic wait_valid_level(input logic level, input string what);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 16) begin
            next_cycle();
            cycles++;
            if (data_valid_out === level) seen = 1'b1;
        end
        if (!seen) begin
            $display("Timeout while waiting for %s", what);
            timeout_count++;
        end
    endtask

    // Stop new items and let the last one leave the stage
    task automatic drain(input string name);
        clk_en        = 1'b1;
        data_valid_in = 1'b0;
        wait_valid_level(1'b0, {name, " to drain"});
    endtask

    task automatic finish_test(input string name);
        int now_errors;
        now_errors = check_errors + timeout_count;
        $display("Test %s done with %0d errors", name, now_errors - errors_before);
        errors_before = now_errors;
    endtask

    // ==============================
    // Test sequence
    // ==============================
    initial begin
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        // Enable held low through reset, so only the reset can clear the valid
        clk_en        = 1'b0;
        operand_a     = '0;
        operand_b     = '0;
        operation     = '0;
        data_valid_in = 1'b1;
        timeout_count = 0;
        errors_before = 0;
        stall_left    = 0;
        void'($urandom(36));

        // Reset and idle
        repeat (8) @(posedge clk_i);
        #2;
        rst_n_i       = 1'b1;
        clk_en        = 1'b1;
        data_valid_in = 1'b0;
        wait_valid_level(1'b0, "valid low after reset");
        repeat (6) drive($urandom, $urandom, random_op(), 1'b0);
        finish_test("reset");

        // Back-to-back random operations
        repeat (400) drive($urandom, $urandom, random_op(), 1'b1);
        drain("random throughput");
        finish_test("random throughput");

        // Corner values
        drive(32'h0, $urandom, {CLASS_COUNT, OP_CLZ}, 1'b1);
        drive(32'h0, $urandom, {CLASS_COUNT, OP_CTZ}, 1'b1);
        drive(32'hFFFF_FFFF, $urandom, {CLASS_COUNT, OP_CPOP}, 1'b1);
        // Upper bits of B take no part in the amount
        drive(32'h8765_4321, 32'h0000_0020, {CLASS_ROTATE, OP_ROL}, 1'b1);
        drive(32'h8765_4321, 32'h0000_001F, {CLASS_ROTATE, OP_ROL}, 1'b1);
        drive(32'h8765_4321, 32'h0000_0000, {CLASS_ROTATE, OP_ROR}, 1'b1);
        drive(32'h8765_4321, 32'hFFFF_FFFF, {CLASS_ROTATE, OP_ROR}, 1'b1);
        drive(32'hF000_0001, 32'h0000_0005, {CLASS_SHADD, OP_SH3ADD}, 1'b1);
        drive(32'h8000_0000, 32'h0000_0001, {CLASS_COMPARE, OP_MAX}, 1'b1);
        drive(32'h8000_0000, 32'h0000_0001, {CLASS_COMPARE, OP_MAXU}, 1'b1);
        drive(32'h8000_0000, 32'h0000_0001, {CLASS_COMPARE, OP_MIN}, 1'b1);
        drive(32'h8000_0000, 32'h0000_0001, {CLASS_COMPARE, OP_MINU}, 1'b1);
        drive(32'h8000_0000, 32'h0000_001F, {CLASS_LOGIC, OP_BEXT}, 1'b1);
        drive(32'h7FFF_FFFF, 32'h0000_001F, {CLASS_LOGIC, OP_BEXT}, 1'b1);
        drive(32'h0000_0000, 32'h0000_001F, {CLASS_LOGIC, OP_BSET}, 1'b1);
        drain("corner values");
        finish_test("corner values");

        // Valid with random gaps
        repeat (200) drive($urandom, $urandom, random_op(), $urandom_range(2, 0) != 0);
        drain("valid following");
        finish_test("valid following");

        // Stretches of enable low while inputs keep moving
        repeat (300) begin
            if (stall_left == 0 && $urandom_range(3, 0) == 0) begin
                stall_left = int'($urandom_range(6, 1));
            end
            clk_en = (stall_left == 0);
            if (stall_left > 0) stall_left--;
            drive($urandom, $urandom, random_op(), $urandom_range(3, 0) != 0);
        end
        drain("stall");
        finish_test("stall");

        // Unused classes and opcodes
        repeat (80) drive($urandom, $urandom, unused_op(), 1'b1);
        drain("unused encodings");
        finish_test("unused encodings");

        $display("Totals: %0d check errors, %0d timeouts", check_errors, timeout_count);
        if (check_errors + timeout_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : bmu_tb

`default_nettype wire

// File: verilog.f
hw/bmu_pkg.sv
hw/bmu_arith_logic.sv
hw/bmu_compare_rotate.sv
hw/bmu_bit_count.sv
hw/bmu_top.sv
verification/bmu_checker.sv
verification/bmu_tb.sv
